// ==== axi_banked_mem.f ====
+incdir+hdl
hdl/axi_banked_mem_pkg.sv
hdl/bank_port_if.sv
hdl/axil_write_port.sv
hdl/axil_read_port.sv
hdl/bank_ctrl.sv
hdl/axi_banked_mem.sv
dv/axi_banked_mem_assert.sv
dv/axi_banked_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the banked AXI4-Lite memory testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f axi_banked_mem.f \
    --top-module axi_banked_mem_tb --Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vaxi_banked_mem_tb > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if grep -qx "Simulation PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== dv/axi_banked_mem_tb.sv ====
/*
 * Testbench for the banked AXI4-Lite memory slave
 * Table-driven AXI traffic against SRAM bank models and a reference memory
 */
`timescale 1ns/10ps
`default_nettype none

`include "axi_banked_mem_params.svh"

module axi_banked_mem_tb;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_OPS    = 19;
  // Reset cycles plus a budget per table entry
  localparam int TIMEOUT    = 40 * NUM_OPS + 8;

  // Operation kinds, RW is a read and a write issued together
  localparam logic [1:0] OP_WR  = 2'd0;
  localparam logic [1:0] OP_RD  = 2'd1;
  localparam logic [1:0] OP_RW  = 2'd2;
  localparam logic [1:0] OP_RD3 = 2'd3;

  typedef struct packed {
    logic [1:0]                kind;
    axi_banked_mem_pkg::addr_t addr;
    axi_banked_mem_pkg::addr_t waddr;
    axi_banked_mem_pkg::data_t data;
    axi_banked_mem_pkg::strb_t strb;
    logic [7:0]                stall;
    axi_banked_mem_pkg::data_t exp;
  } op_t;

  // kind, address, write address for RW, data, strobe, rready stall, first read data
  op_t ops [NUM_OPS] = '{
    '{OP_WR,  32'h0000_0000, 32'h0, 32'h1111_1111, 4'hF, 8'd0, 32'h0},
    '{OP_WR,  32'h0000_0004, 32'h0, 32'h2222_2222, 4'hF, 8'd0, 32'h0},
    '{OP_WR,  32'h0000_0008, 32'h0, 32'h3333_3333, 4'hF, 8'd0, 32'h0},
    '{OP_WR,  32'h0000_000C, 32'h0, 32'h4444_4444, 4'hF, 8'd0, 32'h0},
    '{OP_RD,  32'h0000_0000, 32'h0, 32'h0,         4'h0, 8'd0, 32'h1111_1111},
    '{OP_RD,  32'h0000_0004, 32'h0, 32'h0,         4'h0, 8'd0, 32'h2222_2222},
    '{OP_RD,  32'h0000_0008, 32'h0, 32'h0,         4'h0, 8'd0, 32'h3333_3333},
    '{OP_RD,  32'h0000_000C, 32'h0, 32'h0,         4'h0, 8'd0, 32'h4444_4444},
    // Never written
    '{OP_RD,  32'h0000_0050, 32'h0, 32'h0,         4'h0, 8'd0, 32'h0000_0000},
    // Byte merge, bytes 0 and 2 replaced
    '{OP_WR,  32'h0000_0020, 32'h0, 32'hAABB_CCDD, 4'hF, 8'd0, 32'h0},
    '{OP_WR,  32'h0000_0020, 32'h0, 32'h1122_3344, 4'h5, 8'd0, 32'h0},
    '{OP_RD,  32'h0000_0020, 32'h0, 32'h0,         4'h0, 8'd0, 32'hAA22_CC44},
    // Upper address bits alias
    '{OP_WR,  32'hABC0_0030, 32'h0, 32'h5A5A_5A5A, 4'hF, 8'd0, 32'h0},
    '{OP_RD,  32'h0000_0030, 32'h0, 32'h0,         4'h0, 8'd0, 32'h5A5A_5A5A},
    // Same bank other word, then different banks
    '{OP_RW,  32'h0000_0000, 32'h10, 32'h0BAD_F00D, 4'hF, 8'd0, 32'h1111_1111},
    '{OP_RW,  32'h0000_0004, 32'h18, 32'hCAFE_0001, 4'hF, 8'd0, 32'h2222_2222},
    '{OP_RD,  32'h0000_0010, 32'h0, 32'h0,         4'h0, 8'd0, 32'h0BAD_F00D},
    '{OP_RD3, 32'h0000_0000, 32'h0, 32'h0,         4'h0, 8'd6, 32'h1111_1111},
    '{OP_RD,  32'h0000_0018, 32'h0, 32'h0,         4'h0, 8'd0, 32'hCAFE_0001}
  };

  logic                                            clk_i;
  logic                                            rst_n_i;
  logic                                            awvalid_i;
  logic                                            awready_o;
  axi_banked_mem_pkg::addr_t                       awaddr_i;
  logic                                            wvalid_i;
  logic                                            wready_o;
  axi_banked_mem_pkg::data_t                       wdata_i;
  axi_banked_mem_pkg::strb_t                       wstrb_i;
  logic                                            bvalid_o;
  logic                                            bready_i;
  logic                                            arvalid_i;
  logic                                            arready_o;
  axi_banked_mem_pkg::addr_t                       araddr_i;
  logic                                            rvalid_o;
  logic                                            rready_i;
  axi_banked_mem_pkg::data_t                       rdata_o;
  axi_banked_mem_pkg::bank_vec_t                   mem_req_o;
  axi_banked_mem_pkg::bank_vec_t                   mem_gnt_i = '0;
  axi_banked_mem_pkg::bank_vec_t                   mem_we_o;
  axi_banked_mem_pkg::word_addr_t [`NUM_BANKS-1:0] mem_addr_o;
  axi_banked_mem_pkg::data_t      [`NUM_BANKS-1:0] mem_wdata_o;
  axi_banked_mem_pkg::strb_t      [`NUM_BANKS-1:0] mem_be_o;
  axi_banked_mem_pkg::data_t      [`NUM_BANKS-1:0] mem_rdata_i;
  logic                                            busy_o;

  // SRAM banks, their read pipes and the flat reference memory
  axi_banked_mem_pkg::data_t bank_mem [`NUM_BANKS][2**`MEM_ADDR_W] = '{default: '0};
  axi_banked_mem_pkg::data_t rd_pipe  [`NUM_BANKS][`MEM_LATENCY]   = '{default: '0};
  axi_banked_mem_pkg::data_t ref_mem  [2**(`BANK_SEL_W + `MEM_ADDR_W)] = '{default: '0};

  // Handshakes seen at the last rising edge
  logic                      aw_hs = 1'b0;
  logic                      ar_hs = 1'b0;
  logic                      b_hs  = 1'b0;
  axi_banked_mem_pkg::data_t rx_q [$];
  axi_banked_mem_pkg::data_t exp_q [$];
  integer                    seed = 32'h195d5195;
  int unsigned               cycle_cnt = 0;

  axi_banked_mem axi_banked_mem_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Bank model, byte-enabled writes and fixed read latency
  always @(posedge clk_i) begin
    for (int b = 0; b < `NUM_BANKS; b++) begin
      if (mem_req_o[b] && mem_gnt_i[b]) begin
        if (mem_we_o[b]) begin
          for (int k = 0; k < `STRB_W; k++) begin
            if (mem_be_o[b][k]) begin
              bank_mem[b][mem_addr_o[b]][8*k +: 8] <= mem_wdata_o[b][8*k +: 8];
            end
          end
        end else begin
          rd_pipe[b][0] <= bank_mem[b][mem_addr_o[b]];
        end
      end
      for (int i = 1; i < `MEM_LATENCY; i++) begin
        rd_pipe[b][i] <= rd_pipe[b][i-1];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < `NUM_BANKS; b++) begin
      mem_rdata_i[b] = rd_pipe[b][`MEM_LATENCY-1];
    end
  end

  // Grants withheld at random
  always @(negedge clk_i) begin
    mem_gnt_i = $random(seed);
  end

  always @(posedge clk_i) begin
    aw_hs <= awvalid_i & awready_o & wvalid_i & wready_o;
    ar_hs <= arvalid_i & arready_o;
    b_hs  <= bvalid_o & bready_i;
    if (rvalid_o && rready_i) begin
      rx_q.push_back(rdata_o);
    end
  end

  always @(posedge clk_i) begin
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  // Reference word index, bank and word bits of the byte address
  function automatic int ref_index(input axi_banked_mem_pkg::addr_t a);
    return int'(a[`BYTE_OFS_W +: (`BANK_SEL_W + `MEM_ADDR_W)]);
  endfunction

  // Strobed bytes take the new value
  function automatic axi_banked_mem_pkg::data_t merge_bytes(
    input axi_banked_mem_pkg::data_t old_w,
    input axi_banked_mem_pkg::data_t new_w,
    input axi_banked_mem_pkg::strb_t strb
  );
    axi_banked_mem_pkg::data_t res;
    res = old_w;
    for (int k = 0; k < `STRB_W; k++) begin
      if (strb[k]) begin
        res[8*k +: 8] = new_w[8*k +: 8];
      end
    end
    return res;
  endfunction

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, act, exp);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic do_write(
    input axi_banked_mem_pkg::addr_t a,
    input axi_banked_mem_pkg::data_t d,
    input axi_banked_mem_pkg::strb_t s
  );
    awvalid_i = 1'b1;
    awaddr_i  = a;
    wvalid_i  = 1'b1;
    wdata_i   = d;
    wstrb_i   = s;
    do begin
      @(negedge clk_i);
    end while (!aw_hs);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    ref_mem[ref_index(a)] = merge_bytes(ref_mem[ref_index(a)], d, s);
    do begin
      @(negedge clk_i);
    end while (!b_hs);
  endtask

  // Expected data is fixed when AR is taken
  task automatic issue_read(input axi_banked_mem_pkg::addr_t a);
    arvalid_i = 1'b1;
    araddr_i  = a;
    do begin
      @(negedge clk_i);
    end while (!ar_hs);
    arvalid_i = 1'b0;
    exp_q.push_back(ref_mem[ref_index(a)]);
  endtask

  task automatic collect_reads(input int n, input int stall);
    if (stall > 0) begin
      rready_i = 1'b0;
      repeat (stall) @(negedge clk_i);
      rready_i = 1'b1;
    end
    while (rx_q.size() < n) begin
      @(negedge clk_i);
    end
  endtask

  // Response count, then first word against the table and all against the reference
  task automatic compare_reads(input axi_banked_mem_pkg::data_t tbl_exp);
    axi_banked_mem_pkg::data_t got;
    check("rdata_o count", rx_q.size(), exp_q.size());
    check("rdata_o (table)", rx_q[0], tbl_exp);
    while (rx_q.size() > 0) begin
      got = rx_q.pop_front();
      check("rdata_o", got, exp_q.pop_front());
    end
  endtask

  initial begin
    rst_n_i   = 1'b0;
    awvalid_i = 1'b0;
    awaddr_i  = '0;
    wvalid_i  = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    bready_i  = 1'b1;
    arvalid_i = 1'b0;
    araddr_i  = '0;
    rready_i  = 1'b1;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    check("bvalid_o", bvalid_o, 1'b0);
    check("rvalid_o", rvalid_o, 1'b0);
    check("mem_req_o", mem_req_o, '0);
    check("busy_o", busy_o, 1'b0);
    for (int i = 0; i < NUM_OPS; i++) begin
      case (ops[i].kind)
        OP_WR: do_write(ops[i].addr, ops[i].data, ops[i].strb);
        OP_RD: begin
          fork
            issue_read(ops[i].addr);
            collect_reads(1, ops[i].stall);
          join
          compare_reads(ops[i].exp);
        end
        OP_RW: begin
          fork
            do_write(ops[i].waddr, ops[i].data, ops[i].strb);
            begin
              issue_read(ops[i].addr);
              collect_reads(1, 0);
            end
          join
          compare_reads(ops[i].exp);
        end
        default: begin
          // Three reads back to back while R is stalled
          fork
            begin
              issue_read(ops[i].addr);
              issue_read(ops[i].addr + 32'd4);
              issue_read(ops[i].addr + 32'd8);
            end
            collect_reads(3, ops[i].stall);
          join
          compare_reads(ops[i].exp);
        end
      endcase
      check("busy_o", busy_o, 1'b0);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/axi_banked_mem_assert.sv ====
/*
 * Protocol assertions for the banked AXI4-Lite memory slave
 */
`timescale 1ns/10ps
`default_nettype none

`include "axi_banked_mem_params.svh"

module axi_banked_mem_assert (
  input logic                                            clk_i,
  input logic                                            rst_n_i,
  input logic                                            awready_o,
  input logic                                            wready_o,
  input logic                                            bvalid_o,
  input logic                                            rvalid_o,
  input logic                                            rready_i,
  input axi_banked_mem_pkg::data_t                       rdata_o,
  input axi_banked_mem_pkg::bank_vec_t                   mem_req_o,
  input axi_banked_mem_pkg::bank_vec_t                   mem_gnt_i,
  input axi_banked_mem_pkg::bank_vec_t                   mem_we_o,
  input axi_banked_mem_pkg::word_addr_t [`NUM_BANKS-1:0] mem_addr_o,
  input logic                                            busy_o
);

  // Idle on the first edge out of reset
  assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !bvalid_o && !rvalid_o && (mem_req_o == '0) && !busy_o)
    else $error("outputs not idle after reset");

  // Joint AW/W acceptance
  assert property (@(posedge clk_i) awready_o == wready_o)
    else $error("awready_o and wready_o differ");

  // R payload held under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
    else $error("R response dropped or changed before rready_i");

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : gen_bank
    // Request and its fields locked until granted
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_req_o[b] && !mem_gnt_i[b] |=>
        mem_req_o[b] && $stable(mem_addr_o[b]) && $stable(mem_we_o[b]))
      else $error("bank %0d request changed before grant", b);
  end

endmodule

bind axi_banked_mem axi_banked_mem_assert u_assert (.*);

`default_nettype wire

// ==== hdl/axi_banked_mem.sv ====
/*
 * Banked AXI4-Lite memory slave, top level
 * Independent read and write ports sharing four word-addressed SRAM banks
 */
`timescale 1ns/10ps
`default_nettype none

`include "axi_banked_mem_params.svh"

module axi_banked_mem (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  // AW / W / B
  input  logic                                             awvalid_i,
  output logic                                             awready_o,
  input  axi_banked_mem_pkg::addr_t                        awaddr_i,
  input  logic                                             wvalid_i,
  output logic                                             wready_o,
  input  axi_banked_mem_pkg::data_t                        wdata_i,
  input  axi_banked_mem_pkg::strb_t                        wstrb_i,
  output logic                                             bvalid_o,
  input  logic                                             bready_i,
  // AR / R
  input  logic                                             arvalid_i,
  output logic                                             arready_o,
  input  axi_banked_mem_pkg::addr_t                        araddr_i,
  output logic                                             rvalid_o,
  input  logic                                             rready_i,
  output axi_banked_mem_pkg::data_t                        rdata_o,
  // Banks
  output axi_banked_mem_pkg::bank_vec_t                    mem_req_o,
  input  axi_banked_mem_pkg::bank_vec_t                    mem_gnt_i,
  output axi_banked_mem_pkg::bank_vec_t                    mem_we_o,
  output axi_banked_mem_pkg::word_addr_t [`NUM_BANKS-1:0]  mem_addr_o,
  output axi_banked_mem_pkg::data_t      [`NUM_BANKS-1:0]  mem_wdata_o,
  output axi_banked_mem_pkg::strb_t      [`NUM_BANKS-1:0]  mem_be_o,
  input  axi_banked_mem_pkg::data_t      [`NUM_BANKS-1:0]  mem_rdata_i,
  output logic                                             busy_o
);

  logic wr_busy;
  logic rd_busy;

  bank_port_if wr_bus ();
  bank_port_if rd_bus ();

  axil_write_port u_write_port (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .awaddr_i  (awaddr_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .bus       (wr_bus.wr_mp),
    .busy_o    (wr_busy)
  );

  axil_read_port u_read_port (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .araddr_i  (araddr_i),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .rdata_o   (rdata_o),
    .bus       (rd_bus.rd_mp),
    .busy_o    (rd_busy)
  );

  bank_ctrl u_bank_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr          (wr_bus.ctrl_wr),
    .rd          (rd_bus.ctrl_rd),
    .mem_req_o   (mem_req_o),
    .mem_gnt_i   (mem_gnt_i),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_be_o    (mem_be_o),
    .mem_rdata_i (mem_rdata_i)
  );

  // Either port active
  assign busy_o = wr_busy | rd_busy;

endmodule

`default_nettype wire

// ==== hdl/bank_ctrl.sv ====
/*
 * Bank controller
 * Per-bank read/write arbitration with lock-in, memory drive, read data return
 */
`timescale 1ns/10ps
`default_nettype none

`include "axi_banked_mem_params.svh"

module bank_ctrl (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  bank_port_if.ctrl_wr                                     wr,
  bank_port_if.ctrl_rd                                     rd,
  output axi_banked_mem_pkg::bank_vec_t                    mem_req_o,
  input  axi_banked_mem_pkg::bank_vec_t                    mem_gnt_i,
  output axi_banked_mem_pkg::bank_vec_t                    mem_we_o,
  output axi_banked_mem_pkg::word_addr_t [`NUM_BANKS-1:0]  mem_addr_o,
  output axi_banked_mem_pkg::data_t      [`NUM_BANKS-1:0]  mem_wdata_o,
  output axi_banked_mem_pkg::strb_t      [`NUM_BANKS-1:0]  mem_be_o,
  input  axi_banked_mem_pkg::data_t      [`NUM_BANKS-1:0]  mem_rdata_i
);

  axi_banked_mem_pkg::bank_vec_t wr_gnt;
  axi_banked_mem_pkg::bank_vec_t rd_gnt;
  logic [`MEM_LATENCY-1:0]       sr_valid_q;
  axi_banked_mem_pkg::bank_sel_t sr_bank_q [`MEM_LATENCY];

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : gen_bank
    logic wr_hit;
    logic rd_hit;
    logic sel_wr;
    logic prio_wr_q;
    logic lock_q;
    logic lock_wr_q;

    assign wr_hit = wr.req & (wr.bank == axi_banked_mem_pkg::bank_sel_t'(b));
    assign rd_hit = rd.req & (rd.bank == axi_banked_mem_pkg::bank_sel_t'(b));

    // Locked choice first, else round robin on conflict
    assign sel_wr = lock_q ? lock_wr_q : ((wr_hit & rd_hit) ? prio_wr_q : wr_hit);

    assign mem_req_o[b]   = wr_hit | rd_hit;
    assign mem_we_o[b]    = sel_wr & wr_hit;
    assign mem_addr_o[b]  = sel_wr ? wr.addr : rd.addr;
    // Data and enables only matter on writes
    assign mem_wdata_o[b] = wr.wdata;
    assign mem_be_o[b]    = wr.strb;

    assign wr_gnt[b] = mem_gnt_i[b] & wr_hit & sel_wr;
    assign rd_gnt[b] = mem_gnt_i[b] & rd_hit & ~sel_wr;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        prio_wr_q <= 1'b0;
        lock_q    <= 1'b0;
        lock_wr_q <= 1'b0;
      end else begin
        // Favour the other port next time
        if (mem_req_o[b] & mem_gnt_i[b]) begin
          prio_wr_q <= ~sel_wr;
        end
        // Shown but not granted, keep it
        lock_q    <= mem_req_o[b] & ~mem_gnt_i[b];
        lock_wr_q <= sel_wr;
      end
    end
  end

  // Each port targets one bank at a time
  assign wr.gnt = |wr_gnt;
  assign rd.gnt = |rd_gnt;

  // Read access tracking, MEM_LATENCY stages
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sr_valid_q <= '0;
    end else begin
      sr_valid_q[0] <= rd.gnt;
      for (int i = 1; i < `MEM_LATENCY; i++) begin
        sr_valid_q[i] <= sr_valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    sr_bank_q[0] <= rd.bank;
    for (int i = 1; i < `MEM_LATENCY; i++) begin
      sr_bank_q[i] <= sr_bank_q[i-1];
    end
  end

  // Pick the answering bank
  assign rd.rvalid = sr_valid_q[`MEM_LATENCY-1];
  assign rd.rdata  = mem_rdata_i[sr_bank_q[`MEM_LATENCY-1]];

endmodule

`default_nettype wire

// ==== hdl/axil_read_port.sv ====
/*
 * AXI4-Lite read port
 * Issues bank reads under credit control and buffers R data in order
 */
`timescale 1ns/10ps
`default_nettype none

`include "axi_banked_mem_params.svh"

module axil_read_port (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      arvalid_i,
  output logic                      arready_o,
  input  axi_banked_mem_pkg::addr_t araddr_i,
  output logic                      rvalid_o,
  input  logic                      rready_i,
  output axi_banked_mem_pkg::data_t rdata_o,
  bank_port_if.rd_mp                bus,
  output logic                      busy_o
);

  localparam int unsigned CNT_W = $clog2(`RSP_DEPTH + 1);
  localparam int unsigned PTR_W = $clog2(`RSP_DEPTH);

  logic                           req_q;
  axi_banked_mem_pkg::bank_sel_t  bank_q;
  axi_banked_mem_pkg::word_addr_t addr_q;
  logic                           ar_accept;
  logic                           r_pop;
  logic [CNT_W-1:0]               credit_q;
  logic [CNT_W-1:0]               fill_q;
  logic [PTR_W-1:0]               wr_ptr_q;
  logic [PTR_W-1:0]               rd_ptr_q;
  axi_banked_mem_pkg::data_t      buf_q [`RSP_DEPTH];

  // One open request at a time, and never more reads than buffer slots
  assign arready_o = ~req_q & (credit_q < CNT_W'(`RSP_DEPTH));
  assign ar_accept = arvalid_i & arready_o;
  assign r_pop     = rvalid_o & rready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q    <= 1'b0;
      credit_q <= '0;
      fill_q   <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (ar_accept) begin
        req_q <= 1'b1;
      end else if (bus.gnt) begin
        req_q <= 1'b0;
      end
      // Credit spans acceptance up to the R handshake
      case ({ar_accept, r_pop})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
      case ({bus.rvalid, r_pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
      if (bus.rvalid) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`RSP_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (r_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`RSP_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Address slice, bits above the bank word range are dropped
  always_ff @(posedge clk_i) begin
    if (ar_accept) begin
      bank_q <= araddr_i[`BYTE_OFS_W +: `BANK_SEL_W];
      addr_q <= araddr_i[(`BYTE_OFS_W + `BANK_SEL_W) +: `MEM_ADDR_W];
    end
  end

  // Space is guaranteed by the credit check
  always_ff @(posedge clk_i) begin
    if (bus.rvalid) begin
      buf_q[wr_ptr_q] <= bus.rdata;
    end
  end

  assign bus.req  = req_q;
  assign bus.bank = bank_q;
  assign bus.addr = addr_q;

  assign rvalid_o = (fill_q != '0);
  assign rdata_o  = buf_q[rd_ptr_q];

  // Covers the open request, reads in flight and buffered data
  assign busy_o = (credit_q != '0);

endmodule

`default_nettype wire

// ==== hdl/axil_write_port.sv ====
/*
 * AXI4-Lite write port
 * Takes AW and W together, performs one bank write, then returns B
 */
`timescale 1ns/10ps
`default_nettype none

`include "axi_banked_mem_params.svh"

module axil_write_port (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      awvalid_i,
  output logic                      awready_o,
  input  axi_banked_mem_pkg::addr_t awaddr_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,
  input  axi_banked_mem_pkg::data_t wdata_i,
  input  axi_banked_mem_pkg::strb_t wstrb_i,
  output logic                      bvalid_o,
  input  logic                      bready_i,
  bank_port_if.wr_mp                bus,
  output logic                      busy_o
);

  axi_banked_mem_pkg::wr_state_e  state_q;
  axi_banked_mem_pkg::wr_state_e  state_d;
  logic                           accept;
  axi_banked_mem_pkg::bank_sel_t  bank_q;
  axi_banked_mem_pkg::word_addr_t addr_q;
  axi_banked_mem_pkg::data_t      wdata_q;
  axi_banked_mem_pkg::strb_t      strb_q;

  // AW and W only go through together, and only when idle
  assign accept    = (state_q == axi_banked_mem_pkg::WR_IDLE) & awvalid_i & wvalid_i;
  assign awready_o = accept;
  assign wready_o  = accept;

  always_comb begin
    state_d = state_q;
    case (state_q)
      axi_banked_mem_pkg::WR_IDLE: begin
        if (accept) begin
          state_d = axi_banked_mem_pkg::WR_MEM;
        end
      end
      // Wait here for the bank grant
      axi_banked_mem_pkg::WR_MEM: begin
        if (bus.gnt) begin
          state_d = axi_banked_mem_pkg::WR_RESP;
        end
      end
      // B held until the master takes it
      axi_banked_mem_pkg::WR_RESP: begin
        if (bready_i) begin
          state_d = axi_banked_mem_pkg::WR_IDLE;
        end
      end
      default: state_d = axi_banked_mem_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= axi_banked_mem_pkg::WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Cut bank index and word address out of the byte address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      bank_q  <= awaddr_i[`BYTE_OFS_W +: `BANK_SEL_W];
      addr_q  <= awaddr_i[(`BYTE_OFS_W + `BANK_SEL_W) +: `MEM_ADDR_W];
      wdata_q <= wdata_i;
      strb_q  <= wstrb_i;
    end
  end

  assign bus.req   = (state_q == axi_banked_mem_pkg::WR_MEM);
  assign bus.bank  = bank_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.strb  = strb_q;

  assign bvalid_o = (state_q == axi_banked_mem_pkg::WR_RESP);
  assign busy_o   = (state_q != axi_banked_mem_pkg::WR_IDLE);

endmodule

`default_nettype wire

// ==== hdl/bank_port_if.sv ====
/*
 * Request/grant link between one AXI port module and the bank controller
 */
`timescale 1ns/10ps
`default_nettype none

interface bank_port_if;

  // Request towards the banks, held until gnt
  logic                           req;
  logic                           gnt;
  axi_banked_mem_pkg::bank_sel_t  bank;
  axi_banked_mem_pkg::word_addr_t addr;

  // Write payload, write link only
  axi_banked_mem_pkg::data_t      wdata;
  axi_banked_mem_pkg::strb_t      strb;

  // Read return, read link only
  logic                           rvalid;
  axi_banked_mem_pkg::data_t      rdata;

  modport wr_mp (output req, bank, addr, wdata, strb, input gnt);

  modport rd_mp (output req, bank, addr, input gnt, rvalid, rdata);

  // Controller views
  modport ctrl_wr (input req, bank, addr, wdata, strb, output gnt);

  modport ctrl_rd (input req, bank, addr, output gnt, rvalid, rdata);

endinterface

`default_nettype wire

// ==== hdl/axi_banked_mem_pkg.sv ====
/*
 * Banked AXI4-Lite memory slave
 * Common vector types and write port state encoding
 */
`default_nettype none

`include "axi_banked_mem_params.svh"

package axi_banked_mem_pkg;

  // Byte address as seen on AW/AR
  typedef logic [`AXI_ADDR_W-1:0] addr_t;

  // One bus word equals one bank word
  typedef logic [`DATA_W-1:0]     data_t;
  typedef logic [`STRB_W-1:0]     strb_t;

  // Bank index taken from the low word address bits
  typedef logic [`BANK_SEL_W-1:0] bank_sel_t;

  // Word address inside one bank
  typedef logic [`MEM_ADDR_W-1:0] word_addr_t;

  // One bit per bank
  typedef logic [`NUM_BANKS-1:0]  bank_vec_t;

  // Write port FSM
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_MEM  = 2'd1,
    WR_RESP = 2'd2
  } wr_state_e;

endpackage

`default_nettype wire

// ==== hdl/axi_banked_mem_params.svh ====
/*
 * Banked AXI4-Lite memory slave
 * Shared width, bank count and latency constants
 */
`ifndef AXI_BANKED_MEM_PARAMS_SVH
`define AXI_BANKED_MEM_PARAMS_SVH

// Bus side
`define AXI_ADDR_W  32
`define DATA_W      32
`define STRB_W      (`DATA_W / 8)

// Bank geometry, bank count must be a power of two
`define NUM_BANKS   4
`define BANK_SEL_W  2
`define BYTE_OFS_W  2
`define MEM_ADDR_W  8

// Memory read latency and read response buffer size
`define MEM_LATENCY 1
`define RSP_DEPTH   2

`endif
